/* logic/cpu_pkg.sv */
package cpu_pkg;

	// Write-back source select.
	localparam logic [2:0] SEL_ALU = 3'd0;
	localparam logic [2:0] SEL_MEM = 3'd1; // Load or store.
	localparam logic [2:0] SEL_CSR = 3'd2;

	// Memory operation codes
	// Loads and stores share one 3-bit field.
	localparam logic [2:0] MEM_LB  = 3'd0;
	localparam logic [2:0] MEM_LH  = 3'd1;
	localparam logic [2:0] MEM_LW  = 3'd2;
	localparam logic [2:0] MEM_SB  = 3'd3;
	localparam logic [2:0] MEM_LBU = 3'd4;
	localparam logic [2:0] MEM_LHU = 3'd5;
	localparam logic [2:0] MEM_SH  = 3'd6;
	localparam logic [2:0] MEM_SW  = 3'd7;

	// Cause for a failed data bus access.
	localparam logic [31:0] CAUSE_DMEM_BUS_ERROR = 32'h0000_0005;

	// AXI response codes.
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* logic/dmem_request.sv */
`timescale 1ns/1ps

module dmem_request (
	input  logic        clk,
	input  logic        reset,

	input  logic        valid_in,
	input  logic        ready_out,

	input  logic [2:0]  wb_src_ex,
	input  logic [2:0]  mem_op_ex,
	input  logic        rd_wena_ex,
	input  logic        exc_pend_ex,
	input  logic [31:0] mem_addr_ex,
	input  logic [31:0] store_data_ex,

	output logic [31:0] araddr,
	output logic        arvalid,
	input  logic        arready,

	output logic [31:0] awaddr,
	output logic        awvalid,
	input  logic        awready,
	output logic [31:0] wdata,
	output logic [3:0]  wstrb,
	output logic        wvalid,
	input  logic        wready
);

	logic issued;
	logic aw_done;
	logic w_done;
	logic req;
	logic is_load;
	logic aw_fin;
	logic w_fin;
	logic accept;

	assign req     = valid_in && wb_src_ex == cpu_pkg::SEL_MEM && !exc_pend_ex && !issued;
	assign is_load = rd_wena_ex;
	assign accept  = valid_in && ready_out; // Stage takes the instruction.

	assign araddr  = mem_addr_ex;
	assign awaddr  = mem_addr_ex;
	assign arvalid = req && is_load;
	assign awvalid = req && !is_load && !aw_done;
	assign wvalid  = req && !is_load && !w_done;

	// Write completes once both channels are through.
	assign aw_fin = aw_done || (awvalid && awready);
	assign w_fin  = w_done || (wvalid && wready);

	// Replicate narrow store data across the word.
	always_comb begin
		case (mem_op_ex)
			cpu_pkg::MEM_SB: begin
				wdata = {4{store_data_ex[7:0]}};
				wstrb = 4'b0001 << mem_addr_ex[1:0];
			end
			cpu_pkg::MEM_SH: begin
				wdata = {2{store_data_ex[15:0]}};
				wstrb = mem_addr_ex[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				wdata = store_data_ex;
				wstrb = 4'b1111;
			end
		endcase
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			issued  <= 1'b0;
			aw_done <= 1'b0;
			w_done  <= 1'b0;
		end else if (accept) begin
			issued  <= 1'b0;
			aw_done <= 1'b0;
			w_done  <= 1'b0;
		end else if (arvalid && arready) begin
			issued <= 1'b1;
		end else if (req && !is_load) begin
			if (aw_fin && w_fin) begin
				issued  <= 1'b1;
				aw_done <= 1'b0;
				w_done  <= 1'b0;
			end else begin
				aw_done <= aw_fin;
				w_done  <= w_fin;
			end
		end
	end

endmodule

/* logic/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
	input  logic        clk,
	input  logic        reset,

	input  logic        valid_in,
	output logic        ready_out,
	output logic        valid_out,
	input  logic        ready_in,

	input  logic [31:0] pc_ex,
	input  logic [31:0] ir_ex,
	input  logic        rd_wena_ex,
	input  logic [5:0]  rd_addr_ex,
	input  logic [31:0] rd_data_ex,
	input  logic [11:0] csr_addr_ex,
	input  logic        csr_rena_ex,
	input  logic        csr_wena_ex,
	input  logic [31:0] csr_wdata_ex,
	input  logic [2:0]  wb_src_ex,
	input  logic [2:0]  mem_op_ex,
	input  logic [1:0]  csr_op_ex,
	input  logic        exc_pend_ex,
	input  logic [31:0] exc_cause_ex,

	input  logic [1:0]  bresp,
	input  logic        bvalid,
	output logic        bready,
	input  logic [31:0] araddr,
	input  logic [31:0] rdata,
	input  logic [1:0]  rresp,
	input  logic        rvalid,
	output logic        rready,

	output logic [31:0] pc_mem,
	output logic [31:0] ir_mem,
	output logic        rd_wena_mem,
	output logic [5:0]  rd_addr_mem,
	output logic [31:0] rd_data_mem,
	output logic [11:0] csr_addr_mem,
	output logic        csr_rena_mem,
	output logic        csr_wena_mem,
	output logic [31:0] csr_wdata_mem,
	output logic [2:0]  wb_src_mem,
	output logic [1:0]  csr_op_mem,
	output logic        exc_pend_mem,
	output logic [31:0] exc_cause_mem
);

	logic        stall;
	logic        is_mem;
	logic [31:0] rdata_aligned;

	assign is_mem = wb_src_ex == cpu_pkg::SEL_MEM;

	// Drain behind exceptions and CSR accesses.
	assign stall = exc_pend_mem || csr_rena_mem || csr_wena_mem ||
		(!exc_pend_ex && is_mem &&
		((rd_wena_ex && !rvalid) || (!rd_wena_ex && !bvalid)));

	assign ready_out = ready_in && !stall;

	// Response pops only when the instruction moves on.
	assign rready = ready_out;
	assign bready = ready_out;

	assign rdata_aligned = rdata >> {araddr[1:0], 3'b000};

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			valid_out     <= 1'b0;
			pc_mem        <= '0;
			ir_mem        <= '0;
			rd_wena_mem   <= 1'b0;
			rd_addr_mem   <= '0;
			rd_data_mem   <= '0;
			csr_addr_mem  <= '0;
			csr_rena_mem  <= 1'b0;
			csr_wena_mem  <= 1'b0;
			csr_wdata_mem <= '0;
			wb_src_mem    <= '0;
			csr_op_mem    <= '0;
			exc_pend_mem  <= 1'b0;
			exc_cause_mem <= '0;
		end else if (valid_in && ready_out) begin
			valid_out     <= 1'b1;
			pc_mem        <= pc_ex;
			ir_mem        <= ir_ex;
			rd_wena_mem   <= rd_wena_ex;
			rd_addr_mem   <= rd_addr_ex;
			rd_data_mem   <= rd_data_ex;
			csr_addr_mem  <= csr_addr_ex;
			csr_rena_mem  <= csr_rena_ex;
			csr_wena_mem  <= csr_wena_ex;
			csr_wdata_mem <= csr_wdata_ex;
			wb_src_mem    <= wb_src_ex;
			csr_op_mem    <= csr_op_ex;
			exc_pend_mem  <= exc_pend_ex;
			exc_cause_mem <= exc_cause_ex;

			if (is_mem && !exc_pend_ex) begin
				if (rd_wena_ex) begin
					if (rresp != cpu_pkg::RESP_OKAY) begin
						exc_pend_mem  <= 1'b1;
						exc_cause_mem <= cpu_pkg::CAUSE_DMEM_BUS_ERROR;
					end else begin
						case (mem_op_ex)
							cpu_pkg::MEM_LB:
								rd_data_mem <= {{24{rdata_aligned[7]}}, rdata_aligned[7:0]};
							cpu_pkg::MEM_LBU:
								rd_data_mem <= {24'h000000, rdata_aligned[7:0]};
							cpu_pkg::MEM_LH:
								rd_data_mem <= {{16{rdata_aligned[15]}}, rdata_aligned[15:0]};
							cpu_pkg::MEM_LHU:
								rd_data_mem <= {16'h0000, rdata_aligned[15:0]};
							default:
								rd_data_mem <= rdata_aligned;
						endcase
					end
				end else if (bresp != cpu_pkg::RESP_OKAY) begin // Failed store.
					exc_pend_mem  <= 1'b1;
					exc_cause_mem <= cpu_pkg::CAUSE_DMEM_BUS_ERROR;
				end
			end
		end else if (valid_out && ready_in) begin
			valid_out     <= 1'b0; // Consumed, nothing new.
			pc_mem        <= '0;
			ir_mem        <= '0;
			rd_wena_mem   <= 1'b0;
			rd_addr_mem   <= '0;
			rd_data_mem   <= '0;
			csr_addr_mem  <= '0;
			csr_rena_mem  <= 1'b0;
			csr_wena_mem  <= 1'b0;
			csr_wdata_mem <= '0;
			wb_src_mem    <= '0;
			csr_op_mem    <= '0;
			exc_pend_mem  <= 1'b0;
			exc_cause_mem <= '0;
		end
	end

endmodule

/* logic/data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
	parameter int RAM_WORDS = 256
) (
	input  logic        clk,
	input  logic        reset,

	input  logic [31:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,

	input  logic [31:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready
);

	localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

	logic [31:0] mem [RAM_WORDS];

	logic        aw_held;
	logic        w_held;
	logic [31:0] awaddr_q;
	logic [31:0] wdata_q;
	logic [3:0]  wstrb_q;

	logic        ar_hs;
	logic        aw_hs;
	logic        w_hs;
	logic        wr_go;
	logic [31:0] wr_addr;
	logic [31:0] wr_data;
	logic [3:0]  wr_strb;
	logic        rd_ok;
	logic        wr_ok;
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;

	assign arready = !rvalid && !bvalid;
	assign awready = !rvalid && !bvalid && !aw_held;
	assign wready  = !rvalid && !bvalid && !w_held;

	assign ar_hs = arvalid && arready;
	assign aw_hs = awvalid && awready;
	assign w_hs  = wvalid && wready;
	assign wr_go = (aw_held || aw_hs) && (w_held || w_hs); // Address and data both here.

	assign wr_addr = aw_held ? awaddr_q : awaddr;
	assign wr_data = w_held ? wdata_q : wdata;
	assign wr_strb = w_held ? wstrb_q : wstrb;

	assign rd_ok  = araddr[31:2] < 30'(RAM_WORDS);
	assign wr_ok  = wr_addr[31:2] < 30'(RAM_WORDS);
	assign rd_idx = araddr[IDX_W+1:2];
	assign wr_idx = wr_addr[IDX_W+1:2];

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			rvalid  <= 1'b0;
			bvalid  <= 1'b0;
			aw_held <= 1'b0;
			w_held  <= 1'b0;
		end else begin
			if (ar_hs)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;

			if (wr_go)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;

			aw_held <= !wr_go && (aw_held || aw_hs);
			w_held  <= !wr_go && (w_held || w_hs);
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs)
			awaddr_q <= awaddr;
		if (w_hs) begin
			wdata_q <= wdata;
			wstrb_q <= wstrb;
		end

		if (ar_hs) begin
			rdata <= rd_ok ? mem[rd_idx] : 32'h0;
			rresp <= rd_ok ? cpu_pkg::RESP_OKAY : cpu_pkg::RESP_SLVERR;
		end

		if (wr_go) begin
			bresp <= wr_ok ? cpu_pkg::RESP_OKAY : cpu_pkg::RESP_SLVERR;
			if (wr_ok) begin
				for (int b = 0; b < 4; b++) begin
					if (wr_strb[b])
						mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
				end
			end
		end
	end

endmodule

/* logic/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem #(
	parameter int RAM_WORDS = 256
) (
	input  logic        clk,
	input  logic        reset,

	input  logic        valid_in,
	output logic        ready_out,
	output logic        valid_out,
	input  logic        ready_in,

	input  logic [31:0] pc_ex,
	input  logic [31:0] ir_ex,
	input  logic        rd_wena_ex,
	input  logic [5:0]  rd_addr_ex,
	input  logic [31:0] rd_data_ex,
	input  logic [11:0] csr_addr_ex,
	input  logic        csr_rena_ex,
	input  logic        csr_wena_ex,
	input  logic [31:0] csr_wdata_ex,
	input  logic [2:0]  wb_src_ex,
	input  logic [2:0]  mem_op_ex,
	input  logic [1:0]  csr_op_ex,
	input  logic        exc_pend_ex,
	input  logic [31:0] exc_cause_ex,
	input  logic [31:0] mem_addr_ex,
	input  logic [31:0] store_data_ex,

	output logic [31:0] pc_mem,
	output logic [31:0] ir_mem,
	output logic        rd_wena_mem,
	output logic [5:0]  rd_addr_mem,
	output logic [31:0] rd_data_mem,
	output logic [11:0] csr_addr_mem,
	output logic        csr_rena_mem,
	output logic        csr_wena_mem,
	output logic [31:0] csr_wdata_mem,
	output logic [2:0]  wb_src_mem,
	output logic [1:0]  csr_op_mem,
	output logic        exc_pend_mem,
	output logic [31:0] exc_cause_mem
);

	// Data bus between the request block, the stage and the RAM.
	logic [31:0] araddr;
	logic        arvalid, arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid, rready;
	logic [31:0] awaddr;
	logic        awvalid, awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid, wready;
	logic [1:0]  bresp;
	logic        bvalid, bready;

	dmem_request dmem_request_inst (
		.clk, .reset,
		.valid_in, .ready_out,
		.wb_src_ex, .mem_op_ex, .rd_wena_ex, .exc_pend_ex,
		.mem_addr_ex, .store_data_ex,
		.araddr, .arvalid, .arready,
		.awaddr, .awvalid, .awready,
		.wdata, .wstrb, .wvalid, .wready
	);

	mem_stage mem_stage_inst (
		.clk, .reset,
		.valid_in, .ready_out, .valid_out, .ready_in,
		.pc_ex, .ir_ex, .rd_wena_ex, .rd_addr_ex, .rd_data_ex,
		.csr_addr_ex, .csr_rena_ex, .csr_wena_ex, .csr_wdata_ex,
		.wb_src_ex, .mem_op_ex, .csr_op_ex, .exc_pend_ex, .exc_cause_ex,
		.bresp, .bvalid, .bready,
		.araddr, .rdata, .rresp, .rvalid, .rready,
		.pc_mem, .ir_mem, .rd_wena_mem, .rd_addr_mem, .rd_data_mem,
		.csr_addr_mem, .csr_rena_mem, .csr_wena_mem, .csr_wdata_mem,
		.wb_src_mem, .csr_op_mem, .exc_pend_mem, .exc_cause_mem
	);

	data_ram #(
		.RAM_WORDS(RAM_WORDS)
	) data_ram_inst (
		.clk, .reset,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.awaddr, .awvalid, .awready,
		.wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready
	);

endmodule

/* test/mem_subsystem_assert.sv */
`timescale 1ns/1ps

module mem_subsystem_assert (
	input logic        clk,
	input logic        reset,
	input logic        arvalid,
	input logic        arready,
	input logic        awvalid,
	input logic        awready,
	input logic        valid_out,
	input logic        ready_in,
	input logic [31:0] pc_mem,
	input logic [31:0] ir_mem,
	input logic [31:0] rd_data_mem,
	input logic        exc_pend_mem
);

	ar_hold: assert property (@(posedge clk) disable iff (reset)
		arvalid && !arready |=> arvalid)
		else $error("arvalid dropped before it was accepted.");

	aw_hold: assert property (@(posedge clk) disable iff (reset)
		awvalid && !awready |=> awvalid)
		else $error("awvalid dropped before it was accepted.");

	// Output item frozen while write-back stalls.
	out_hold: assert property (@(posedge clk) disable iff (reset)
		valid_out && !ready_in |=> valid_out && $stable(pc_mem) && $stable(ir_mem) &&
		$stable(rd_data_mem) && $stable(exc_pend_mem))
		else $error("Output item changed under low ready_in.");

	single_read: assert property (@(posedge clk) disable iff (reset)
		arvalid && arready |=> !arvalid)
		else $error("Second read issued for one instruction.");

endmodule

/* test/mem_subsystem_tb.sv */
`timescale 1ns/1ps

module mem_subsystem_tb;

	localparam int RAM_WORDS = 256;
	localparam int ITERS = 8; // Store and load rounds.
	localparam int STREAM = 40; // Items under back-pressure.
	localparam int TEST_CYCLES = ITERS * 8 * 4 + STREAM * 16 + 600;

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic        valid_in = 1'b0;
	logic        ready_in = 1'b1;
	logic [31:0] pc_ex = '0;
	logic [31:0] ir_ex = '0;
	logic        rd_wena_ex = 1'b0;
	logic [5:0]  rd_addr_ex = '0;
	logic [31:0] rd_data_ex = '0;
	logic [11:0] csr_addr_ex = '0;
	logic        csr_rena_ex = 1'b0;
	logic        csr_wena_ex = 1'b0;
	logic [31:0] csr_wdata_ex = '0;
	logic [2:0]  wb_src_ex = '0;
	logic [2:0]  mem_op_ex = '0;
	logic [1:0]  csr_op_ex = '0;
	logic        exc_pend_ex = 1'b0;
	logic [31:0] exc_cause_ex = '0;
	logic [31:0] mem_addr_ex = '0;
	logic [31:0] store_data_ex = '0;

	logic        ready_out, valid_out;
	logic [31:0] pc_mem, ir_mem, rd_data_mem, csr_wdata_mem, exc_cause_mem;
	logic        rd_wena_mem, csr_rena_mem, csr_wena_mem, exc_pend_mem;
	logic [5:0]  rd_addr_mem;
	logic [11:0] csr_addr_mem;
	logic [2:0]  wb_src_mem;
	logic [1:0]  csr_op_mem;

	logic [7:0]  ref_mem [RAM_WORDS*4]; // Byte image of the RAM.
	logic [31:0] exp_pc[$];
	logic [31:0] exp_ir[$];
	logic [31:0] exp_data[$];
	logic [31:0] exp_cause[$];
	logic        exp_exc[$];
	logic [25:0] exp_side[$]; // Fields that pass straight through.
	logic [31:0] exp_csrw[$];
	logic [31:0] words[$]; // Fully written word addresses.
	logic [31:0] pc_next = 32'h0000_0100;
	logic        rand_ready = 1'b0;
	logic [2:0]  load_ops [5] = '{cpu_pkg::MEM_LB, cpu_pkg::MEM_LBU, cpu_pkg::MEM_LH,
		cpu_pkg::MEM_LHU, cpu_pkg::MEM_LW};

	mem_subsystem #(
		.RAM_WORDS(RAM_WORDS)
	) mem_subsystem_inst (.*);

	bind mem_subsystem mem_subsystem_assert mem_subsystem_assert_inst (
		.clk(clk), .reset(reset), .arvalid(arvalid), .arready(arready),
		.awvalid(awvalid), .awready(awready), .valid_out(valid_out), .ready_in(ready_in),
		.pc_mem(pc_mem), .ir_mem(ir_mem), .rd_data_mem(rd_data_mem),
		.exc_pend_mem(exc_pend_mem)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		#1;
		ready_in = rand_ready ? ($urandom % 3 != 0) : 1'b1;
	end

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s: got %08h, expected %08h", $time, what, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "Value mismatch.");
		end
	endtask

	task automatic fail(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "Run stopped.");
	endtask

	// Expected load value straight from the byte image.
	function automatic logic [31:0] load_value(input logic [2:0] op, input logic [31:0] addr);
		int a;
		a = int'(addr);
		case (op)
			cpu_pkg::MEM_LB:  return {{24{ref_mem[a][7]}}, ref_mem[a]};
			cpu_pkg::MEM_LBU: return {24'h0, ref_mem[a]};
			cpu_pkg::MEM_LH:  return {{16{ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
			cpu_pkg::MEM_LHU: return {16'h0, ref_mem[a+1], ref_mem[a]};
			default:          return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
		endcase
	endfunction

	task automatic store_model(input logic [2:0] op, input logic [31:0] addr,
			input logic [31:0] data);
		int a;
		a = int'(addr);
		ref_mem[a] = data[7:0];
		if (op != cpu_pkg::MEM_SB)
			ref_mem[a+1] = data[15:8];
		if (op == cpu_pkg::MEM_SW) begin
			ref_mem[a+2] = data[23:16];
			ref_mem[a+3] = data[31:24];
		end
	endtask

	// Byte offset legal for the access size.
	function automatic logic [31:0] pick_offset(input logic [2:0] op);
		case (op)
			cpu_pkg::MEM_LB, cpu_pkg::MEM_LBU, cpu_pkg::MEM_SB: return $urandom % 4;
			cpu_pkg::MEM_LH, cpu_pkg::MEM_LHU, cpu_pkg::MEM_SH: return 2 * ($urandom % 2);
			default: return 32'h0;
		endcase
	endfunction

	task automatic issue(input logic [2:0] src, input logic [2:0] op, input logic [31:0] addr,
			input logic [31:0] sdata, input logic exc, input logic csr, output int waits);
		logic [31:0] my_pc;
		logic [31:0] exp_d;
		logic [31:0] exp_c;
		logic        exp_e;
		logic        load;
		load = src == cpu_pkg::SEL_MEM && op != cpu_pkg::MEM_SB &&
			op != cpu_pkg::MEM_SH && op != cpu_pkg::MEM_SW;
		my_pc = pc_next;
		pc_next = pc_next + 32'd4;
		pc_ex = my_pc;
		ir_ex = $urandom();
		rd_wena_ex = load || src != cpu_pkg::SEL_MEM;
		rd_addr_ex = 6'($urandom());
		rd_data_ex = $urandom();
		csr_addr_ex = csr ? 12'h300 : 12'h000;
		csr_rena_ex = csr;
		csr_wena_ex = csr;
		csr_wdata_ex = csr ? $urandom() : 32'h0;
		csr_op_ex = csr ? 2'd1 : 2'd0;
		wb_src_ex = src;
		mem_op_ex = op;
		exc_pend_ex = exc;
		exc_cause_ex = exc ? 32'd2 : 32'd0;
		mem_addr_ex = addr;
		store_data_ex = sdata;
		valid_in = 1'b1;

		exp_d = rd_data_ex;
		exp_e = exc;
		exp_c = exc_cause_ex;
		if (src == cpu_pkg::SEL_MEM && !exc) begin
			if (addr[31:2] >= 30'(RAM_WORDS)) begin
				exp_e = 1'b1;
				exp_c = cpu_pkg::CAUSE_DMEM_BUS_ERROR;
			end else if (load) begin
				exp_d = load_value(op, addr);
			end else begin
				store_model(op, addr, sdata);
			end
		end
		exp_pc.push_back(my_pc);
		exp_ir.push_back(ir_ex);
		exp_data.push_back(exp_d);
		exp_exc.push_back(exp_e);
		exp_cause.push_back(exp_c);
		exp_side.push_back({rd_wena_ex, rd_addr_ex, csr_addr_ex, csr_rena_ex, csr_wena_ex,
			wb_src_ex, csr_op_ex});
		exp_csrw.push_back(csr_wdata_ex);

		waits = 0;
		@(negedge clk);
		while (!ready_out) begin
			waits++;
			if (waits > 50)
				fail("Handshake timeout: ready_out never rose for the held instruction.");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		valid_in = 1'b0;
		check("valid_out after acceptance", 32'(valid_out), 32'd1);
		check("pc_mem after acceptance", pc_mem, my_pc);
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_pc.size() != 0) begin
			@(posedge clk);
			n++;
			if (n > 200)
				fail("Expected output items never appeared.");
		end
		#1;
	endtask

	// Every consumed item is compared in order.
	always @(negedge clk) begin
		if (!reset && valid_out && ready_in) begin
			if (exp_pc.size() == 0) begin
				fail("An output item appeared with nothing expected.");
			end else begin
				check("pc_mem", pc_mem, exp_pc.pop_front());
				check("ir_mem", ir_mem, exp_ir.pop_front());
				check("rd_data_mem", rd_data_mem, exp_data.pop_front());
				check("exc_pend_mem", 32'(exc_pend_mem), 32'(exp_exc.pop_front()));
				check("exc_cause_mem", exc_cause_mem, exp_cause.pop_front());
				check("pass-through fields", 32'({rd_wena_mem, rd_addr_mem, csr_addr_mem,
					csr_rena_mem, csr_wena_mem, wb_src_mem, csr_op_mem}),
					32'(exp_side.pop_front()));
				check("csr_wdata_mem", csr_wdata_mem, exp_csrw.pop_front());
			end
		end
	end

	task automatic reset_and_alu();
		int waits;
		@(negedge clk);
		check("valid_out after reset", 32'(valid_out), 32'd0);
		check("ready_out after reset", 32'(ready_out), 32'd1);
		check("pc_mem after reset", pc_mem, 32'd0);
		@(posedge clk);
		#1;
		issue(cpu_pkg::SEL_ALU, cpu_pkg::MEM_LW, 32'h0, 32'h0, 1'b0, 1'b0, waits);
		check("ALU accept wait", 32'(waits), 32'd0);
		drain();
	endtask

	task automatic store_load_rounds();
		int waits;
		logic [31:0] w;
		logic [31:0] base;
		logic [2:0]  op;
		for (int i = 0; i < ITERS; i++) begin
			w = $urandom % RAM_WORDS;
			base = {w[29:0], 2'b00};
			words.push_back(base);
			issue(cpu_pkg::SEL_MEM, cpu_pkg::MEM_SW, base, $urandom(), 1'b0, 1'b0, waits);
			check("store latency", 32'(waits), 32'd1);
			issue(cpu_pkg::SEL_MEM, cpu_pkg::MEM_SB, base + pick_offset(cpu_pkg::MEM_SB),
				$urandom(), 1'b0, 1'b0, waits);
			issue(cpu_pkg::SEL_MEM, cpu_pkg::MEM_SH, base + pick_offset(cpu_pkg::MEM_SH),
				$urandom(), 1'b0, 1'b0, waits);
			for (int k = 0; k < 5; k++) begin
				op = load_ops[k];
				issue(cpu_pkg::SEL_MEM, op, base + pick_offset(op), 32'h0, 1'b0, 1'b0, waits);
				check("load latency", 32'(waits), 32'd1);
			end
		end
		drain();
	endtask

	task automatic bus_errors();
		int waits;
		logic [31:0] bad;
		bad = 32'(RAM_WORDS * 4 + 16); // Would alias word 4 if written.
		words.push_back(32'h10);
		issue(cpu_pkg::SEL_MEM, cpu_pkg::MEM_SW, 32'h10, 32'h0bad_cafe, 1'b0, 1'b0, waits);
		issue(cpu_pkg::SEL_MEM, cpu_pkg::MEM_SW, bad, 32'hdead_beef, 1'b0, 1'b0, waits);
		issue(cpu_pkg::SEL_ALU, cpu_pkg::MEM_LW, 32'h0, 32'h0, 1'b0, 1'b0, waits);
		check("wait behind store bus error", 32'(waits), 32'd1);
		issue(cpu_pkg::SEL_MEM, cpu_pkg::MEM_LW, bad, 32'h0, 1'b0, 1'b0, waits);
		issue(cpu_pkg::SEL_ALU, cpu_pkg::MEM_LW, 32'h0, 32'h0, 1'b0, 1'b0, waits);
		check("wait behind load bus error", 32'(waits), 32'd1);
		issue(cpu_pkg::SEL_MEM, cpu_pkg::MEM_LW, 32'h10, 32'h0, 1'b0, 1'b0, waits);
		drain();
	endtask

	task automatic exception_passthrough();
		int waits;
		issue(cpu_pkg::SEL_MEM, cpu_pkg::MEM_SW, words[0], 32'h1234_5678, 1'b1, 1'b0, waits);
		check("exception item wait", 32'(waits), 32'd0);
		issue(cpu_pkg::SEL_MEM, cpu_pkg::MEM_LW, words[0], 32'h0, 1'b0, 1'b0, waits);
		drain();
	endtask

	task automatic csr_blocking();
		int waits;
		issue(cpu_pkg::SEL_CSR, cpu_pkg::MEM_LW, 32'h0, 32'h0, 1'b0, 1'b1, waits);
		check("CSR accept wait", 32'(waits), 32'd0);
		issue(cpu_pkg::SEL_ALU, cpu_pkg::MEM_LW, 32'h0, 32'h0, 1'b0, 1'b0, waits);
		check("wait behind CSR", 32'(waits), 32'd1);
		drain();
	endtask

	task automatic backpressure_stream();
		int waits;
		logic [31:0] a;
		logic [2:0]  op;
		rand_ready = 1'b1;
		for (int i = 0; i < STREAM; i++) begin
			a = words[$urandom % words.size()];
			case ($urandom % 3)
				0: begin
					op = ($urandom % 2 == 0) ? cpu_pkg::MEM_SB : cpu_pkg::MEM_SH;
					if ($urandom % 3 == 0)
						op = cpu_pkg::MEM_SW;
					issue(cpu_pkg::SEL_MEM, op, a + pick_offset(op), $urandom(), 1'b0, 1'b0,
						waits);
				end
				1: begin
					op = load_ops[$urandom % 5];
					issue(cpu_pkg::SEL_MEM, op, a + pick_offset(op), 32'h0, 1'b0, 1'b0, waits);
				end
				default: issue(cpu_pkg::SEL_ALU, cpu_pkg::MEM_LW, 32'h0, 32'h0, 1'b0, 1'b0, waits);
			endcase
		end
		foreach (words[j])
			issue(cpu_pkg::SEL_MEM, cpu_pkg::MEM_LW, words[j], 32'h0, 1'b0, 1'b0, waits);
		drain();
		rand_ready = 1'b0;
	endtask

	initial begin
		#(TEST_CYCLES * 100);
		$display("Timeout: the tests did not finish within %0d cycles.", TEST_CYCLES);
		$display("CHECKS FAILED");
		$fatal(1, "Watchdog expired.");
	end

	initial begin
		void'($urandom(32'hb2b2f5f1));
		repeat (2) @(posedge clk);
		@(negedge clk);
		check("valid_out in reset", 32'(valid_out), 32'd0);
		@(posedge clk);
		#1;
		reset = 1'b0;

		reset_and_alu();
		store_load_rounds();
		bus_errors();
		exception_passthrough();
		csr_blocking();
		backpressure_stream();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* flist.f */
logic/cpu_pkg.sv
logic/dmem_request.sv
logic/mem_stage.sv
logic/data_ram.sv
logic/mem_subsystem.sv
test/mem_subsystem_assert.sv
test/mem_subsystem_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mem_subsystem_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SRCS      = $(wildcard logic/*.sv test/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
